// File: Bender.yml
package:
  name: cabinet_io

export_include_dirs:
  - .

sources:
  - cabinet_io_pkg.sv
  - spi_user_io.sv
  - player_controls.sv
  - sigma_delta_dac.sv
  - cabinet_io_top.sv
  - target: test
    files:
      - cabinet_io_asserts.sv
      - cabinet_io_tb.sv

// File: cabinet_io_asserts.sv
`timescale 1ns/1ps

module cabinet_io_asserts
	import cabinet_io_pkg::*;
(
	input logic        clk_10,
	input logic        arst_n,
	input logic        key_strobe,
	input key_code_e   key_code,
	input logic [9:0]  buttons
);

	// break and extended prefixes never reach the button logic
	strobe_code_valid: assert property (@(posedge clk_10) disable iff (!arst_n)
		key_strobe |-> !(key_code inside {key_release, 8'hE0}))
		else $error("key_strobe carried a prefix byte as key code");

	strobe_single_cycle: assert property (@(posedge clk_10) disable iff (!arst_n)
		key_strobe |=> !key_strobe)
		else $error("key_strobe high for two cycles");

	// buttons only move one cycle after a strobe
	buttons_need_strobe: assert property (@(posedge clk_10) disable iff (!arst_n)
		!$past(key_strobe) |-> $stable(buttons))
		else $error("button changed without a key strobe");

endmodule

bind player_controls cabinet_io_asserts asserts_i (
	.clk_10     (clk_10),
	.arst_n     (arst_n),
	.key_strobe (key_strobe),
	.key_code   (key_code),
	.buttons    ({btn_up, btn_down, btn_left, btn_right, btn_fire1, btn_fire2, btn_fire3,
		btn_start1, btn_start2, btn_coin})
);

// File: cabinet_io_config.svh
`ifndef CABINET_IO_CONFIG_SVH
`define CABINET_IO_CONFIG_SVH

// audio sample width into the sigma-delta dac
`define CABINET_DAC_WIDTH 16

// flip-flops per serial input before edge detection
`define CABINET_SYNC_STAGES 2

// bytes of the core status word
`define CABINET_STATUS_BYTES 4

`endif

// File: cabinet_io_pkg.sv
package cabinet_io_pkg;

	// commands from the control microcontroller
	typedef enum logic [7:0] {
		cmd_joy0    = 8'h01,
		cmd_joy1    = 8'h02,
		cmd_ps2_key = 8'h05,
		cmd_status  = 8'h1E
	} spi_cmd_e;

	// serial receiver, first byte is the command
	typedef enum logic {
		rx_cmd  = 1'b0,
		rx_data = 1'b1
	} spi_state_e;

	// ps/2 set 2 scan codes of the mapped keys
	typedef enum logic [7:0] {
		key_f1      = 8'h05,
		key_f2      = 8'h06,
		key_alt     = 8'h11,
		key_ctrl    = 8'h14,
		key_space   = 8'h29,
		key_left    = 8'h6B,
		key_down    = 8'h72,
		key_right   = 8'h74,
		key_up      = 8'h75,
		key_esc     = 8'h76,
		key_release = 8'hF0  // break prefix
	} key_code_e;

endpackage

// File: cabinet_io_tb.sv
`timescale 1ns/1ps
`include "cabinet_io_config.svh"

module cabinet_io_tb
	import cabinet_io_pkg::*;
();

	logic                          clk_10;
	logic                          arst_n;
	logic                          spi_sck;
	logic                          spi_di;
	logic                          spi_ss_io;
	logic [`CABINET_DAC_WIDTH-1:0] audio;
	logic up, down, left, right, fire, bomb, start1, start2, coin;
	logic game_reset, blend, audio_out;
	logic [1:0] scanlines;
	logic [12:0] observed;
	logic [7:0] joy0_m, joy1_m;  // expected joystick bytes
	logic [31:0] status_m;
	logic [8:0] keys_m;  // held keys, same order as the controls
	int errors, timeouts, checks;
	string test_name;
	string ctl_names [9] = '{"coin", "start2", "start1", "bomb", "fire", "right", "left",
		"down", "up"};
	key_code_e mapped_keys [10] = '{key_up, key_down, key_left, key_right, key_space,
		key_alt, key_ctrl, key_esc, key_f1, key_f2};

	cabinet_io_top dut_i (.*);

	assign observed = {up, down, left, right, fire, bomb, start1, start2, coin,
		game_reset, scanlines, blend};

	initial begin
		clk_10 = 1'b0;
		forever #10 clk_10 = ~clk_10;
	end

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_10);
			#2;  // drive point after the edge
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		wait_cycles(2);
		arst_n = 1'b1;
	endtask

	task automatic shift_out_bits(input logic [7:0] value, input int count);
		for (int i = 7; i > 7 - count; i--) begin  // msb first
			spi_di  = value[i];
			spi_sck = 1'b0;
			wait_cycles(8);
			spi_sck = 1'b1;
			wait_cycles(8);
		end
	endtask

	task automatic spi_send_byte(input logic [7:0] value);
		shift_out_bits(value, 8);
	endtask

	task automatic deselect();
		spi_sck = 1'b0;
		wait_cycles(8);
		spi_ss_io = 1'b1;
		wait_cycles(8);
	endtask

	task automatic spi_transfer(input spi_cmd_e cmd, input logic [31:0] data, input int nbytes);
		spi_ss_io = 1'b0;
		wait_cycles(8);
		spi_send_byte(cmd);
		for (int i = 0; i < nbytes; i++) spi_send_byte(data[i*8 +: 8]);  // low byte first
		deselect();
	endtask

	task automatic wait_for_output(input logic [12:0] expected);
		int n;
		n = 0;
		while (observed !== expected && n < 64) begin
			wait_cycles(1);
			n++;
		end
		if (observed !== expected) begin
			timeouts++;
			$display("timeout in %s: outputs never reached %h within 64 cycles", test_name,
				expected);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s %s: expected %0b, actual %0b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_bits2(input string what, input logic [1:0] expected,
		input logic [1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("** Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	function automatic int output_slot(input key_code_e k);
		case (k)
			key_up:    return 8;
			key_down:  return 7;
			key_left:  return 6;
			key_right: return 5;
			key_space: return 4;
			key_alt:   return 3;
			key_f1:    return 2;
			key_f2:    return 1;
			key_esc:   return 0;
			default:   return -1;  // ctrl and unmapped codes
		endcase
	endfunction

	function automatic logic [12:0] expected_outputs();
		logic [7:0] j;
		logic [8:0] ctl;
		j   = joy0_m | joy1_m;
		ctl = keys_m | {j[3], j[2], j[1], j[0], j[4], j[5], 3'b000};
		return {ctl, status_m[0] | status_m[6], status_m[4:3], status_m[5]};
	endfunction

	task automatic check_outputs();
		logic [12:0] exp;
		exp = expected_outputs();
		wait_for_output(exp);
		for (int i = 0; i < 9; i++) check_bit(ctl_names[i], exp[i+4], observed[i+4]);
		check_bit("game_reset", exp[3], observed[3]);
		check_bits2("scanlines", exp[2:1], observed[2:1]);
		check_bit("blend", exp[0], observed[0]);
	endtask

	task automatic press_key(input key_code_e k, input logic pressed);
		int slot;
		if (pressed)
			spi_transfer(cmd_ps2_key, {24'h0, k}, 1);
		else
			spi_transfer(cmd_ps2_key, {16'h0, k, key_release}, 2);  // break prefix goes first
		slot = output_slot(k);
		if (slot >= 0) keys_m[slot] = pressed;
		check_outputs();
	endtask

	task automatic test_reset();
		test_name = "reset";
		check_outputs();
		check_bit("audio_out", 1'b0, audio_out);
	endtask

	task automatic test_keys();
		key_code_e other;
		test_name = "keys";
		foreach (mapped_keys[i]) begin
			press_key(mapped_keys[i], 1'b1);
			press_key(mapped_keys[i], 1'b0);
		end
		other = key_code_e'(8'($urandom_range(8'h5F, 8'h30)));  // clear of every mapped code
		press_key(other, 1'b1);
		press_key(other, 1'b0);
	endtask

	task automatic test_joystick();
		test_name = "joystick";
		repeat (8) begin
			joy0_m = 8'($urandom);
			joy1_m = 8'($urandom);
			spi_transfer(cmd_joy0, {24'h0, joy0_m}, 1);
			spi_transfer(cmd_joy1, {24'h0, joy1_m}, 1);
			check_outputs();
		end
		press_key(key_up, 1'b1);
		joy0_m = 8'h00;
		joy1_m = 8'h00;
		spi_transfer(cmd_joy0, 32'h0, 1);
		spi_transfer(cmd_joy1, 32'h0, 1);
		check_outputs();
		press_key(key_up, 1'b0);
	endtask

	task automatic test_status();
		test_name = "status";
		repeat (6) begin
			status_m = $urandom;
			spi_transfer(cmd_status, status_m, 4);
			check_outputs();
		end
	endtask

	task automatic test_abort();
		test_name = "abort";
		spi_ss_io = 1'b0;
		wait_cycles(8);
		spi_send_byte(cmd_joy0);
		shift_out_bits(~joy0_m, 4);  // half a byte then deselect
		deselect();
		check_outputs();
		joy0_m = 8'($urandom);
		spi_transfer(cmd_joy0, {24'h0, joy0_m}, 1);
		check_outputs();
	endtask

	task automatic test_dac(input logic [`CABINET_DAC_WIDTH-1:0] sample);
		int ones;
		test_name = "dac";
		audio = sample;
		apply_reset();
		ones = 0;
		repeat (4096) begin
			wait_cycles(1);
			ones += audio_out;
		end
		check_count("audio_out ones", (4096 * int'(sample)) / 65536, ones);
	endtask

	initial begin
		void'($urandom(32'h0ab1180d));
		spi_sck   = 1'b0;
		spi_di    = 1'b0;
		spi_ss_io = 1'b1;
		audio     = '0;
		arst_n    = 1'b0;
		joy0_m    = 8'h00;
		joy1_m    = 8'h00;
		status_m  = 32'h0;
		keys_m    = 9'h000;
		errors    = 0;
		timeouts  = 0;
		checks    = 0;
		wait_cycles(2);
		arst_n = 1'b1;
		test_reset();
		test_keys();
		test_joystick();
		test_status();
		test_abort();
		test_dac(16'h4000);
		test_dac(16'h0000);
		$display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: cabinet_io_top.f
+incdir+.
cabinet_io_pkg.sv
spi_user_io.sv
player_controls.sv
sigma_delta_dac.sv
cabinet_io_top.sv
cabinet_io_asserts.sv
cabinet_io_tb.sv

// File: cabinet_io_top.sv
`timescale 1ns/1ps
`include "cabinet_io_config.svh"

module cabinet_io_top
	import cabinet_io_pkg::*;
(
	input  logic                          clk_10,
	input  logic                          arst_n,
	input  logic                          spi_sck,
	input  logic                          spi_di,
	input  logic                          spi_ss_io,
	input  logic [`CABINET_DAC_WIDTH-1:0] audio,
	output logic                          up,
	output logic                          down,
	output logic                          left,
	output logic                          right,
	output logic                          fire,
	output logic                          bomb,
	output logic                          start1,
	output logic                          start2,
	output logic                          coin,
	output logic                          game_reset,
	output logic [1:0]                    scanlines,
	output logic                          blend,
	output logic                          audio_out
);

	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [31:0] status;
	logic        key_strobe;
	logic        key_pressed;
	key_code_e   key_code;

	spi_user_io user_io_i (
		.clk_10      (clk_10),
		.arst_n      (arst_n),
		.spi_sck     (spi_sck),
		.spi_di      (spi_di),
		.spi_ss_io   (spi_ss_io),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.status      (status),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code)
	);

	player_controls controls_i (
		.clk_10      (clk_10),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.status      (status),
		.up          (up),
		.down        (down),
		.left        (left),
		.right       (right),
		.fire        (fire),
		.bomb        (bomb),
		.start1      (start1),
		.start2      (start2),
		.coin        (coin),
		.game_reset  (game_reset),
		.scanlines   (scanlines),
		.blend       (blend)
	);

	sigma_delta_dac dac_i (
		.clk_10    (clk_10),
		.arst_n    (arst_n),
		.audio     (audio),
		.audio_out (audio_out)
	);

endmodule

// File: player_controls.sv
`timescale 1ns/1ps

module player_controls
	import cabinet_io_pkg::*;
(
	input  logic        clk_10,
	input  logic        arst_n,
	input  logic        key_strobe,
	input  logic        key_pressed,
	input  key_code_e   key_code,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic [31:0] status,
	output logic        up,
	output logic        down,
	output logic        left,
	output logic        right,
	output logic        fire,
	output logic        bomb,
	output logic        start1,
	output logic        start2,
	output logic        coin,
	output logic        game_reset,
	output logic [1:0]  scanlines,
	output logic        blend
);

	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire1;
	logic btn_fire2;
	logic btn_fire3;
	logic btn_start1;
	logic btn_start2;
	logic btn_coin;

	always_ff @(posedge clk_10 or negedge arst_n) begin
		if (!arst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
			btn_fire3  <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_coin   <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				key_up:    btn_up     <= key_pressed;
				key_down:  btn_down   <= key_pressed;
				key_left:  btn_left   <= key_pressed;
				key_right: btn_right  <= key_pressed;
				key_space: btn_fire1  <= key_pressed;
				key_alt:   btn_fire2  <= key_pressed;
				key_ctrl:  btn_fire3  <= key_pressed;  // not wired to the game
				key_esc:   btn_coin   <= key_pressed;
				key_f1:    btn_start1 <= key_pressed;
				key_f2:    btn_start2 <= key_pressed;
				default: ;
			endcase
		end
	end

	// keyboard or either joystick
	assign up     = btn_up    | joystick_0[3] | joystick_1[3];
	assign down   = btn_down  | joystick_0[2] | joystick_1[2];
	assign left   = btn_left  | joystick_0[1] | joystick_1[1];
	assign right  = btn_right | joystick_0[0] | joystick_1[0];
	assign fire   = btn_fire1 | joystick_0[4] | joystick_1[4];
	assign bomb   = btn_fire2 | joystick_0[5] | joystick_1[5];
	assign start1 = btn_start1;
	assign start2 = btn_start2;
	assign coin   = btn_coin;

	assign game_reset = status[0] | status[6];  // menu reset or core reset bit
	assign scanlines  = status[4:3];
	assign blend      = status[5];

endmodule

// File: sigma_delta_dac.sv
`timescale 1ns/1ps
`include "cabinet_io_config.svh"

module sigma_delta_dac (
	input  logic                          clk_10,
	input  logic                          arst_n,
	input  logic [`CABINET_DAC_WIDTH-1:0] audio,
	output logic                          audio_out
);

	localparam int W = `CABINET_DAC_WIDTH;

	logic [W:0] acc;  // top bit holds the carry of the last add

	// first order, the carry density tracks audio / 2**W
	always_ff @(posedge clk_10 or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[W-1:0]} + {1'b0, audio};
		end
	end

	assign audio_out = acc[W];

endmodule

// File: spi_user_io.sv
`timescale 1ns/1ps
`include "cabinet_io_config.svh"

module spi_user_io
	import cabinet_io_pkg::*;
(
	input  logic        clk_10,
	input  logic        arst_n,
	input  logic        spi_sck,
	input  logic        spi_di,
	input  logic        spi_ss_io,
	output logic [7:0]  joystick_0,
	output logic [7:0]  joystick_1,
	output logic [31:0] status,
	output logic        key_strobe,
	output logic        key_pressed,
	output key_code_e   key_code
);

	localparam int SYNC  = `CABINET_SYNC_STAGES;
	localparam int IDX_W = $clog2(`CABINET_STATUS_BYTES) + 1;

	logic [SYNC-1:0]  sck_sync;
	logic [SYNC-1:0]  di_sync;
	logic [SYNC-1:0]  ss_sync;
	logic             sck_d;
	logic             sck_rise;
	logic             ss_high;
	logic [6:0]       shift;
	logic [2:0]       bit_cnt;
	logic [7:0]       rx_byte;
	spi_state_e       state;
	spi_cmd_e         cmd;
	logic [IDX_W-1:0] status_idx;
	logic             release_flag;

	always_ff @(posedge clk_10 or negedge arst_n) begin
		if (!arst_n) begin
			sck_sync <= '0;
			di_sync  <= '0;
			ss_sync  <= '0;
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[SYNC-2:0], spi_sck};
			di_sync  <= {di_sync[SYNC-2:0], spi_di};
			ss_sync  <= {ss_sync[SYNC-2:0], spi_ss_io};
			sck_d    <= sck_sync[SYNC-1];
		end
	end

	assign sck_rise = sck_sync[SYNC-1] & ~sck_d;
	assign ss_high  = ss_sync[SYNC-1];
	assign rx_byte  = {shift, di_sync[SYNC-1]};  // msb first

	always_ff @(posedge clk_10 or negedge arst_n) begin
		if (!arst_n) begin
			shift        <= '0;
			bit_cnt      <= '0;
			state        <= rx_cmd;
			cmd          <= spi_cmd_e'(8'h00);
			status_idx   <= '0;
			release_flag <= 1'b0;
			joystick_0   <= '0;
			joystick_1   <= '0;
			status       <= '0;
			key_strobe   <= 1'b0;
			key_pressed  <= 1'b0;
			key_code     <= key_code_e'(8'h00);
		end else begin
			key_strobe <= 1'b0;
			if (ss_high) begin  // deselect drops a partial byte
				bit_cnt    <= '0;
				state      <= rx_cmd;
				status_idx <= '0;
			end else if (sck_rise) begin
				shift   <= rx_byte[6:0];
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					case (state)
						rx_cmd: begin
							cmd   <= spi_cmd_e'(rx_byte);
							state <= rx_data;
						end
						rx_data: begin
							case (cmd)
								cmd_joy0: joystick_0 <= rx_byte;
								cmd_joy1: joystick_1 <= rx_byte;
								cmd_status: begin
									// lsb first, extra bytes dropped
									if (status_idx < IDX_W'(`CABINET_STATUS_BYTES)) begin
										status[status_idx*8 +: 8] <= rx_byte;
										status_idx <= status_idx + 1'b1;
									end
								end
								cmd_ps2_key: begin
									if (rx_byte == key_release) begin
										release_flag <= 1'b1;
									end else if (rx_byte != 8'hE0) begin
										key_strobe   <= 1'b1;
										key_code     <= key_code_e'(rx_byte);
										key_pressed  <= ~release_flag;
										release_flag <= 1'b0;
									end
								end
								default: ;  // unknown command, wait for deselect
							endcase
						end
					endcase
				end
			end
		end
	end

endmodule
